// ==== rtl/dma_pkg.sv ====
/*
 * Shared address map, sizes and DMA step encoding
 * for the OAM DMA subsystem
 */
package dma_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // DMA source page register
    localparam logic [ADDR_W-1:0] DMA_REG_ADDR = 16'hFF46;

    // Copy destination high byte, OAM lives at FE00-FE9F
    localparam logic [DATA_W-1:0] OAM_PAGE = 8'hFE;

    // Bytes per copy, last index 9F
    localparam int OAM_LEN = 160;

    // High-RAM window, still reachable by the CPU during a copy
    localparam logic [ADDR_W-1:0] HRAM_BASE = 16'hFF80;
    localparam logic [ADDR_W-1:0] HRAM_LAST = 16'hFFFE;

    // Memory sizes in bytes
    localparam int HRAM_DEPTH = 128;
    localparam int MAIN_DEPTH = 65536;

    // Read value for a CPU access blocked by a copy
    localparam logic [DATA_W-1:0] BLOCKED_DATA = 8'hFF;

    // DMA engine sequence, four cycles per byte
    typedef enum logic [2:0] {
        IDLE,
        RD_ADDR,
        RD_WAIT,
        WR_DATA,
        WR_WAIT
    } dma_step_t;

endpackage

// ==== rtl/mem_bus_if.sv ====
/*
 * Byte memory bus with master and slave modports
 */
`timescale 1ns/1ps

interface mem_bus_if import dma_pkg::*; ();

    // Single-cycle strobes
    logic              rd;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    // Valid the cycle after rd
    logic [DATA_W-1:0] rdata;

    modport master (
        output rd,
        output wr,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  rd,
        input  wr,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== rtl/apb_cpu_port.sv ====
/*
 * APB slave for the CPU side, maps transfers onto the memory bus
 * and decodes the DMA register
 */
`timescale 1ns/1ps

module apb_cpu_port import dma_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              dma_reg_wr,
    output logic [DATA_W-1:0] dma_reg_data,
    input  logic [DATA_W-1:0] dma_page,
    mem_bus_if.master         bus
);

    logic is_dma_reg;
    logic access;
    logic first_access;
    logic mem_rd;
    logic mem_wr;
    // Set during the inserted wait state of a memory read
    logic wait_q;

    assign is_dma_reg = (paddr == DMA_REG_ADDR);

    // Access phase, split into first cycle and wait cycle
    assign access       = psel & penable;
    assign first_access = access & ~wait_q;

    // One strobe per transfer, register accesses stay off the bus
    assign mem_rd = first_access & ~pwrite & ~is_dma_reg;
    assign mem_wr = first_access & pwrite & ~is_dma_reg;

    // Page register write pulse
    assign dma_reg_wr   = first_access & pwrite & is_dma_reg;
    assign dma_reg_data = pwdata;

    // Writes and register reads finish at once
    // Memory reads finish in the wait cycle
    assign pready = (first_access & (pwrite | is_dma_reg)) | (access & wait_q);

    // Register readback or memory data, paddr held through the transfer
    assign prdata = is_dma_reg ? dma_page : bus.rdata;

    assign bus.rd    = mem_rd;
    assign bus.wr    = mem_wr;
    assign bus.addr  = paddr;
    assign bus.wdata = pwdata;

    // Wait flag follows the read strobe by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= mem_rd;
        end
    end

endmodule

// ==== rtl/dma_engine.sv ====
/*
 * OAM DMA engine, copies 160 bytes from a source page to FE00
 * Holds the page register and the busy flag
 */
`timescale 1ns/1ps

module dma_engine import dma_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              dma_reg_wr,
    input  logic [DATA_W-1:0] dma_reg_data,
    output logic [DATA_W-1:0] dma_page,
    output logic              dma_busy,
    mem_bus_if.master         bus
);

    dma_step_t         step;
    // Byte index, low half of both addresses
    logic [DATA_W-1:0] count;
    logic [DATA_W-1:0] page;
    // Byte in flight between read and write
    logic [DATA_W-1:0] data_q;
    logic              last_byte;

    assign last_byte = (count == DATA_W'(OAM_LEN - 1));

    assign dma_page = page;
    // High from RD_ADDR of byte 0 through WR_WAIT of byte 159
    assign dma_busy = (step != IDLE);

    // Read strobe in RD_ADDR, write strobe in WR_DATA
    assign bus.rd    = (step == RD_ADDR);
    assign bus.wr    = (step == WR_DATA);
    assign bus.wdata = data_q;

    always_comb begin
        if (step == WR_DATA) begin
            bus.addr = {OAM_PAGE, count};
        end else begin
            bus.addr = {page, count};
        end
    end

    // Step sequence
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step  <= IDLE;
            count <= '0;
            page  <= '0;
        end else begin
            case (step)
                IDLE: begin
                    // Start only from idle, later pulses are ignored
                    if (dma_reg_wr) begin
                        page  <= dma_reg_data;
                        count <= '0;
                        step  <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    step <= RD_WAIT;
                end
                RD_WAIT: begin
                    step <= WR_DATA;
                end
                WR_DATA: begin
                    step <= WR_WAIT;
                end
                WR_WAIT: begin
                    if (last_byte) begin
                        count <= '0;
                        step  <= IDLE;
                    end else begin
                        count <= count + 1'b1;
                        step  <= RD_ADDR;
                    end
                end
                default: begin
                    step <= IDLE;
                end
            endcase
        end
    end

    // Read data is valid in RD_WAIT, held for the write
    always_ff @(posedge clk) begin
        if (step == RD_WAIT) begin
            data_q <= bus.rdata;
        end
    end

endmodule

// ==== rtl/bus_arbiter.sv ====
/*
 * Bus arbiter, steers CPU and DMA requests to main memory and high-RAM
 * CPU loses main memory for the length of a copy
 */
`timescale 1ns/1ps

module bus_arbiter import dma_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      dma_busy,
    mem_bus_if.slave  cpu,
    mem_bus_if.slave  dma,
    mem_bus_if.master main,
    mem_bus_if.master hram
);

    logic cpu_in_hram;
    logic cpu_to_main;
    // Route of the last CPU read, for the data returned next cycle
    logic hram_sel_q;
    logic blocked_q;

    assign cpu_in_hram = (cpu.addr >= HRAM_BASE) && (cpu.addr <= HRAM_LAST);
    assign cpu_to_main = ~cpu_in_hram & ~dma_busy;

    // High-RAM belongs to the CPU at all times
    assign hram.rd    = cpu.rd & cpu_in_hram;
    assign hram.wr    = cpu.wr & cpu_in_hram;
    assign hram.addr  = cpu.addr;
    assign hram.wdata = cpu.wdata;

    // Main memory goes to the engine while busy
    // Blocked CPU strobes are dropped here
    always_comb begin
        if (dma_busy) begin
            main.rd    = dma.rd;
            main.wr    = dma.wr;
            main.addr  = dma.addr;
            main.wdata = dma.wdata;
        end else begin
            main.rd    = cpu.rd & cpu_to_main;
            main.wr    = cpu.wr & cpu_to_main;
            main.addr  = cpu.addr;
            main.wdata = cpu.wdata;
        end
    end

    // Engine only reads main memory
    assign dma.rdata = main.rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hram_sel_q <= 1'b0;
            blocked_q  <= 1'b0;
        end else if (cpu.rd) begin
            hram_sel_q <= cpu_in_hram;
            blocked_q  <= ~cpu_in_hram & dma_busy;
        end
    end

    // Blocked reads see FF
    always_comb begin
        if (blocked_q) begin
            cpu.rdata = BLOCKED_DATA;
        end else if (hram_sel_q) begin
            cpu.rdata = hram.rdata;
        end else begin
            cpu.rdata = main.rdata;
        end
    end

endmodule

// ==== rtl/sync_ram.sv ====
/*
 * Single-port byte RAM, synchronous write and registered read
 */
`timescale 1ns/1ps

module sync_ram import dma_pkg::*; #(
    parameter int DEPTH = 128
) (
    input  logic     clk,
    mem_bus_if.slave bus
);

    logic [DATA_W-1:0]        mem [DEPTH];
    // Low address bits only, the window decode is upstream
    logic [$clog2(DEPTH)-1:0] idx;
    logic [DATA_W-1:0]        rdata_q;

    assign idx = bus.addr[$clog2(DEPTH)-1:0];

    always_ff @(posedge clk) begin
        if (bus.wr) begin
            mem[idx] <= bus.wdata;
        end
        // Data out one cycle after rd
        if (bus.rd) begin
            rdata_q <= mem[idx];
        end
    end

    assign bus.rdata = rdata_q;

endmodule

// ==== rtl/oam_dma_top.sv ====
/*
 * OAM DMA subsystem top level with APB ports
 * Holds the CPU port, DMA engine, arbiter, main RAM and high-RAM
 */
`timescale 1ns/1ps

module oam_dma_top import dma_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [DATA_W-1:0] pwdata,
    output logic [DATA_W-1:0] prdata,
    output logic              pready,
    output logic              dma_busy
);

    // Port to engine
    logic              dma_reg_wr;
    logic [DATA_W-1:0] dma_reg_data;
    logic [DATA_W-1:0] dma_page;

    // Bus masters and memory buses
    mem_bus_if cpu_bus ();
    mem_bus_if dma_bus ();
    mem_bus_if main_bus ();
    mem_bus_if hram_bus ();

    apb_cpu_port u_apb_port (
        .clk          (clk),
        .rst          (rst),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .dma_reg_wr   (dma_reg_wr),
        .dma_reg_data (dma_reg_data),
        .dma_page     (dma_page),
        .bus          (cpu_bus.master)
    );

    dma_engine u_dma_engine (
        .clk          (clk),
        .rst          (rst),
        .dma_reg_wr   (dma_reg_wr),
        .dma_reg_data (dma_reg_data),
        .dma_page     (dma_page),
        .dma_busy     (dma_busy),
        .bus          (dma_bus.master)
    );

    bus_arbiter u_bus_arbiter (
        .clk      (clk),
        .rst      (rst),
        .dma_busy (dma_busy),
        .cpu      (cpu_bus.slave),
        .dma      (dma_bus.slave),
        .main     (main_bus.master),
        .hram     (hram_bus.master)
    );

    // Full 64K space, OAM included
    sync_ram #(.DEPTH(MAIN_DEPTH)) u_main_ram (
        .clk (clk),
        .bus (main_bus.slave)
    );

    sync_ram #(.DEPTH(HRAM_DEPTH)) u_hram (
        .clk (clk),
        .bus (hram_bus.slave)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
/*
 * Testbench clock and reset, 10 ns period, reset held for three cycles
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Released on the third rising edge
    initial begin
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== bench/oam_dma_chk.sv ====
/*
 * Bound assertions on DMA strobes, main memory arbitration and APB ready
 */
`timescale 1ns/1ps

module oam_dma_chk import dma_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic [ADDR_W-1:0] paddr,
    input logic              psel,
    input logic              penable,
    input logic              pwrite,
    input logic              pready,
    input logic              dma_busy,
    input logic [DATA_W-1:0] dma_page,
    input logic              dma_rd,
    input logic              dma_wr,
    input logic              main_rd,
    input logic              main_wr,
    input logic [ADDR_W-1:0] main_addr
);

    // Read, wait, write, wait, never both strobes in one cycle
    a_dma_rd_wr: assert property (@(posedge clk) disable iff (rst)
        dma_rd |-> !dma_wr ##1 (!dma_rd && !dma_wr) ##1 (dma_wr && !dma_rd)
                   ##1 (!dma_rd && !dma_wr))
        else $error("DMA strobes out of the read, wait, write, wait order");

    // During a copy main memory sees only source page reads and OAM writes
    a_main_owner: assert property (@(posedge clk) disable iff (rst)
        dma_busy |-> (!main_rd || main_addr[ADDR_W-1:DATA_W] == dma_page)
                  && (!main_wr || main_addr[ADDR_W-1:DATA_W] == OAM_PAGE))
        else $error("CPU strobe reached main memory during a copy");

    // Ready only inside an access phase
    // A memory read gets it only after its wait cycle
    a_pready: assert property (@(posedge clk) disable iff (rst)
        pready |-> psel && penable
                   && (pwrite || paddr == DMA_REG_ADDR || $past(psel && penable)))
        else $error("pready high outside an APB access phase");

endmodule

bind oam_dma_top oam_dma_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pready    (pready),
    .dma_busy  (dma_busy),
    .dma_page  (dma_page),
    .dma_rd    (dma_bus.rd),
    .dma_wr    (dma_bus.wr),
    .main_rd   (main_bus.rd),
    .main_wr   (main_bus.wr),
    .main_addr (main_bus.addr)
);

// ==== bench/oam_dma_tb.sv ====
/*
 * Table-driven testbench for the OAM DMA subsystem
 * APB transfer task, value check, copy length monitor, cycle timeout
 */
`timescale 1ns/1ps

module oam_dma_tb import dma_pkg::*; ();

    typedef enum logic [1:0] {
        OP_WR,
        OP_RD,
        OP_WAIT
    } op_t;

    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] exp;
    } step_t;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              dma_busy;

    step_t             steps [$];
    // Expected bytes of source pages C0 and D0
    logic [DATA_W-1:0] page_a [OAM_LEN];
    logic [DATA_W-1:0] page_b [OAM_LEN];
    int                cycles = 0;
    int                cycle_limit = 1000000;
    // Cycles of the copy in progress
    int                busy_len = 0;

    tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    oam_dma_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .dma_busy (dma_busy)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: dma_busy never fell within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Four cycles per byte, counted on falling edges while busy
    always @(negedge clk) begin
        if (dma_busy === 1'b1) begin
            busy_len <= busy_len + 1;
        end else if (busy_len != 0) begin
            check("dma_busy cycles", 16'(busy_len), 16'(OAM_LEN * 4));
            busy_len <= 0;
        end
    end

    // One APB transfer, memory reads expect one wait state
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        int waits;
        waits = 0;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waits < 3) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        check($sformatf("pready wait cycles [%h]", addr), 16'(waits),
              (!wr && addr != DMA_REG_ADDR) ? 16'd1 : 16'd0);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic add_step(input op_t op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] exp);
        steps.push_back({op, addr, data, exp});
    endtask

    task automatic build_steps();
        // Idle access to main memory and high-RAM
        add_step(OP_WR, 16'h1234, 8'hA5, 8'h00);
        add_step(OP_RD, 16'h1234, 8'h00, 8'hA5);
        add_step(OP_WR, 16'hFF90, 8'h3C, 8'h00);
        add_step(OP_RD, 16'hFF90, 8'h00, 8'h3C);
        // Page D0 is the inverse of C0 so the two copies always differ
        for (int i = 0; i < OAM_LEN; i++) begin
            page_a[i] = 8'($urandom());
            page_b[i] = ~page_a[i];
            add_step(OP_WR, {8'hC0, 8'(i)}, page_a[i], 8'h00);
            add_step(OP_WR, {8'hD0, 8'(i)}, page_b[i], 8'h00);
        end
        add_step(OP_WR, 16'hFEA0, 8'h5A, 8'h00);
        // First copy, CPU traffic while it runs
        add_step(OP_WR, DMA_REG_ADDR, 8'hC0, 8'h00);
        add_step(OP_RD, DMA_REG_ADDR, 8'h00, 8'hC0);
        add_step(OP_RD, 16'h1234, 8'h00, 8'hFF);
        add_step(OP_WR, 16'h1234, 8'h77, 8'h00);
        add_step(OP_WR, 16'hFF91, 8'hC3, 8'h00);
        add_step(OP_RD, 16'hFF91, 8'h00, 8'hC3);
        // Second start request while busy is ignored
        add_step(OP_WR, DMA_REG_ADDR, 8'hD0, 8'h00);
        add_step(OP_RD, DMA_REG_ADDR, 8'h00, 8'hC0);
        add_step(OP_WAIT, 16'h0000, 8'h00, 8'h00);
        for (int i = 0; i < OAM_LEN; i++) begin
            add_step(OP_RD, {OAM_PAGE, 8'(i)}, 8'h00, page_a[i]);
        end
        add_step(OP_RD, 16'hFEA0, 8'h00, 8'h5A);
        add_step(OP_RD, 16'h1234, 8'h00, 8'hA5);
        add_step(OP_RD, 16'hFF90, 8'h00, 8'h3C);
        // Second copy from page D0
        add_step(OP_WR, DMA_REG_ADDR, 8'hD0, 8'h00);
        add_step(OP_RD, DMA_REG_ADDR, 8'h00, 8'hD0);
        add_step(OP_WAIT, 16'h0000, 8'h00, 8'h00);
        for (int i = 0; i < OAM_LEN; i++) begin
            add_step(OP_RD, {OAM_PAGE, 8'(i)}, 8'h00, page_b[i]);
        end
    endtask

    initial begin
        step_t             s;
        logic [DATA_W-1:0] rd;
        void'($urandom(24));
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        build_steps();
        // At most 4 cycles per transfer, plus two copies of 640 cycles
        cycle_limit = steps.size() * 4 + 2 * 700;
        wait (rst === 1'b0);
        @(negedge clk);
        check("pready after reset", 16'(pready), 16'h0);
        check("dma_busy after reset", 16'(dma_busy), 16'h0);
        foreach (steps[i]) begin
            s = steps[i];
            case (s.op)
                OP_WR: begin
                    apb_xfer(1'b1, s.addr, s.data, rd);
                end
                OP_RD: begin
                    apb_xfer(1'b0, s.addr, 8'h00, rd);
                    check($sformatf("prdata[%h]", s.addr), 16'(rd), 16'(s.exp));
                end
                default: begin
                    @(negedge clk);
                    // Copy still running after the few transfers since the start
                    check("dma_busy during copy", 16'(dma_busy), 16'h1);
                    while (dma_busy) begin
                        @(negedge clk);
                    end
                end
            endcase
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/dma_pkg.sv
rtl/mem_bus_if.sv
rtl/apb_cpu_port.sv
rtl/dma_engine.sv
rtl/bus_arbiter.sv
rtl/sync_ram.sv
rtl/oam_dma_top.sv
bench/tb_clk_gen.sv
bench/oam_dma_chk.sv
bench/oam_dma_tb.sv

// ==== Makefile ====
# Verilator simulation of the OAM DMA subsystem

VERILATOR ?= verilator
TOP       ?= oam_dma_tb
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
